// File: rtl/uart_rx_pkg.sv
package uart_rx_pkg;

  // --------------------
  // Bit timing
  localparam int OVERSAMPLE  = 16;                   // Ticks per bit
  localparam int CNT_W       = $clog2(OVERSAMPLE);   // Tick counter width
  localparam int SYNC_STAGES = 2;                    // Input flop chain depth

  typedef logic [CNT_W-1:0] tick_t;

  localparam tick_t TICK_LAST    = tick_t'(OVERSAMPLE - 1); // Counter wraps here
  localparam tick_t SAMPLE_FIRST = 5;                      // First filter sample
  localparam tick_t SAMPLE_LAST  = 7;                      // Third sample, decision
  localparam tick_t BIT_CENTER   = 8;                      // Bit-center strobe tick
  localparam tick_t START_OFFSET = 2;                      // Covers sync delay

  // --------------------
  // Character and FIFO sizes
  localparam int CHAR_W     = 8;
  localparam int IDX_W      = $clog2(CHAR_W);
  localparam int FIFO_DEPTH = 16;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);

  typedef logic [IDX_W-1:0] bit_idx_t;
  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   fill_t;     // One extra bit to hold a full count

  // --------------------
  // Encodings
  typedef enum logic [1:0] {WORD_LEN_5, WORD_LEN_6, WORD_LEN_7, WORD_LEN_8} word_len_e;
  typedef enum logic [1:0] {PARITY_ODD, PARITY_EVEN, PARITY_ONE, PARITY_ZERO} parity_e;
  typedef enum logic [1:0] {TRIG_1, TRIG_4, TRIG_8, TRIG_14} trig_level_e;
  typedef enum logic [2:0] {
    RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP, RX_RESYNC
  } rx_state_e;

  typedef struct packed {
    word_len_e   word_len;
    logic        parity_en;
    parity_e     parity;
    trig_level_e trig_level;  // FIFO threshold
  } line_cfg_t;

  typedef struct packed {
    logic bit_center;  // One clock at each bit center
    logic bit_val;     // Majority decision
    logic start_edge;  // Line low while hunting
  } sample_t;

  typedef struct packed {
    logic              parity_err;
    logic              framing_err;
    logic              brk;
    logic [CHAR_W-1:0] data;  // Unused upper bits stay zero
  } rx_char_t;

endpackage

// File: rtl/uart_rx_sampler.sv
`timescale 1ns/10ps

module uart_rx_sampler (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 oversample_tick_i,
  input  logic                 rxd_i,
  input  logic                 hunt_i,
  output uart_rx_pkg::sample_t sample_o
);

  logic [uart_rx_pkg::SYNC_STAGES-1:0] sync_q;      // Flop chain, LSB first
  logic                                rxd_sync;
  uart_rx_pkg::tick_t                  tick_cnt_q;
  logic [1:0]                          high_cnt_q;  // High samples seen so far
  logic                                bit_val_q;
  logic                                center_lvl;
  logic                                center_q;

  // --------------------
  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[uart_rx_pkg::SYNC_STAGES-2:0], rxd_i};
    end
  end

  assign rxd_sync = sync_q[uart_rx_pkg::SYNC_STAGES-1];

  // --------------------
  // Tick counter
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tick_cnt_q <= '0;
    end else if (hunt_i) begin
      // Held at zero until a start edge
      if (!rxd_sync && oversample_tick_i) begin
        tick_cnt_q <= uart_rx_pkg::START_OFFSET;  // Tick already taken this clock
      end else begin
        tick_cnt_q <= '0;
      end
    end else if (oversample_tick_i) begin
      if (tick_cnt_q == uart_rx_pkg::TICK_LAST) begin
        tick_cnt_q <= '0;
      end else begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
    end
  end

  // --------------------
  // Majority of three samples
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      high_cnt_q <= '0;
      bit_val_q  <= 1'b1;  // Idle line level
    end else if (oversample_tick_i && !hunt_i) begin
      if (tick_cnt_q == uart_rx_pkg::SAMPLE_FIRST) begin
        high_cnt_q <= {1'b0, rxd_sync};              // Restart the count
      end else if (tick_cnt_q > uart_rx_pkg::SAMPLE_FIRST &&
                   tick_cnt_q < uart_rx_pkg::SAMPLE_LAST) begin
        high_cnt_q <= high_cnt_q + {1'b0, rxd_sync};
      end else if (tick_cnt_q == uart_rx_pkg::SAMPLE_LAST) begin
        // Last sample folded straight into the decision
        bit_val_q <= (high_cnt_q + {1'b0, rxd_sync}) >= 2'd2;
      end
    end
  end

  // Counter dwells at center for a whole tick period
  assign center_lvl = (tick_cnt_q == uart_rx_pkg::BIT_CENTER);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      center_q <= 1'b0;
    end else begin
      center_q <= center_lvl;
    end
  end

  assign sample_o.bit_center = center_lvl & ~center_q;  // First clock at center
  assign sample_o.bit_val    = bit_val_q;
  assign sample_o.start_edge = hunt_i & ~rxd_sync;

endmodule

// File: rtl/uart_rx_frame.sv
`timescale 1ns/10ps

module uart_rx_frame (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  uart_rx_pkg::sample_t   sample_i,
  input  uart_rx_pkg::line_cfg_t cfg_i,
  output logic                   hunt_o,
  output logic                   char_valid_o,
  output uart_rx_pkg::rx_char_t  char_o
);

  uart_rx_pkg::rx_state_e        state_q, state_d;
  uart_rx_pkg::bit_idx_t         bit_idx_q, bit_idx_d;
  uart_rx_pkg::bit_idx_t         last_idx;                // Index of the last data bit
  logic [uart_rx_pkg::CHAR_W-1:0] shift_q, shift_d;
  logic                          par_err_q, par_err_d;
  logic                          all_zero_q, all_zero_d;  // No one seen in this frame
  logic                          par_bad;
  logic                          push_d;
  uart_rx_pkg::rx_char_t         char_d;
  logic                          center;
  logic                          rx_bit;

  assign center = sample_i.bit_center;
  assign rx_bit = sample_i.bit_val;
  assign hunt_o = (state_q == uart_rx_pkg::RX_IDLE) || (state_q == uart_rx_pkg::RX_RESYNC);

  // --------------------
  // Word length and parity decode
  always_comb begin
    case (cfg_i.word_len)
      uart_rx_pkg::WORD_LEN_5: last_idx = 3'd4;
      uart_rx_pkg::WORD_LEN_6: last_idx = 3'd5;
      uart_rx_pkg::WORD_LEN_7: last_idx = 3'd6;
      default:                 last_idx = 3'd7;
    endcase

    case (cfg_i.parity)
      uart_rx_pkg::PARITY_ODD:  par_bad = ((^shift_q) == rx_bit);
      uart_rx_pkg::PARITY_EVEN: par_bad = ((^shift_q) != rx_bit);
      uart_rx_pkg::PARITY_ONE:  par_bad = ~rx_bit;
      default:                  par_bad = rx_bit;  // Forced zero
    endcase
  end

  // --------------------
  // Frame FSM
  always_comb begin
    state_d    = state_q;
    bit_idx_d  = bit_idx_q;
    shift_d    = shift_q;
    par_err_d  = par_err_q;
    all_zero_d = all_zero_q;
    push_d     = 1'b0;
    char_d     = char_o;

    case (state_q)
      uart_rx_pkg::RX_IDLE: begin
        if (sample_i.start_edge) state_d = uart_rx_pkg::RX_START;
      end
      uart_rx_pkg::RX_START: begin
        if (center) begin
          if (rx_bit) begin
            state_d = uart_rx_pkg::RX_IDLE;  // False start
          end else begin
            state_d    = uart_rx_pkg::RX_DATA;
            bit_idx_d  = '0;
            shift_d    = '0;                 // Keeps unused upper bits zero
            par_err_d  = 1'b0;
            all_zero_d = 1'b1;
          end
        end
      end
      uart_rx_pkg::RX_DATA: begin
        if (center) begin
          shift_d[bit_idx_q] = rx_bit;       // LSB first
          all_zero_d         = all_zero_q & ~rx_bit;
          bit_idx_d          = bit_idx_q + 1'b1;
          if (bit_idx_q == last_idx) begin
            state_d = cfg_i.parity_en ? uart_rx_pkg::RX_PARITY : uart_rx_pkg::RX_STOP;
          end
        end
      end
      uart_rx_pkg::RX_PARITY: begin
        if (center) begin
          par_err_d  = par_bad;
          all_zero_d = all_zero_q & ~rx_bit;
          state_d    = uart_rx_pkg::RX_STOP;
        end
      end
      uart_rx_pkg::RX_STOP: begin
        if (center) begin
          push_d             = 1'b1;
          char_d.parity_err  = par_err_q;
          char_d.framing_err = ~rx_bit;
          char_d.brk         = all_zero_q & ~rx_bit;  // Whole frame low
          char_d.data        = shift_q;
          state_d = rx_bit ? uart_rx_pkg::RX_IDLE : uart_rx_pkg::RX_RESYNC;
        end
      end
      uart_rx_pkg::RX_RESYNC: begin
        // Line may already be low again
        state_d = sample_i.start_edge ? uart_rx_pkg::RX_START : uart_rx_pkg::RX_IDLE;
      end
      default: state_d = uart_rx_pkg::RX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= uart_rx_pkg::RX_IDLE;
      bit_idx_q    <= '0;
      char_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      bit_idx_q    <= bit_idx_d;
      char_valid_o <= push_d;  // One clock after the stop center
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q    <= shift_d;
    par_err_q  <= par_err_d;
    all_zero_q <= all_zero_d;
    char_o     <= char_d;
  end

endmodule

// File: rtl/uart_rx_fifo.sv
`timescale 1ns/10ps

module uart_rx_fifo (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     push_i,
  input  uart_rx_pkg::rx_char_t    char_i,
  input  logic                     pop_i,
  input  uart_rx_pkg::trig_level_e trig_level_i,
  output uart_rx_pkg::rx_char_t    char_o,
  output logic                     not_empty_o,
  output logic                     trigger_o,
  output logic                     overrun_o
);

  uart_rx_pkg::rx_char_t mem_q [uart_rx_pkg::FIFO_DEPTH];
  uart_rx_pkg::ptr_t     wr_ptr_q;
  uart_rx_pkg::ptr_t     rd_ptr_q;
  uart_rx_pkg::fill_t    count_q;
  uart_rx_pkg::fill_t    thresh;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full        = (count_q == uart_rx_pkg::fill_t'(uart_rx_pkg::FIFO_DEPTH));
  assign not_empty_o = (count_q != '0);
  assign do_pop      = pop_i & not_empty_o;      // Pop on empty is ignored
  assign do_push     = push_i & (~full | do_pop); // Room frees up on a same-clock pop
  assign char_o      = mem_q[rd_ptr_q];           // Head, valid while not empty

  // --------------------
  // Trigger threshold
  always_comb begin
    case (trig_level_i)
      uart_rx_pkg::TRIG_1:  thresh = uart_rx_pkg::fill_t'(1);
      uart_rx_pkg::TRIG_4:  thresh = uart_rx_pkg::fill_t'(4);
      uart_rx_pkg::TRIG_8:  thresh = uart_rx_pkg::fill_t'(8);
      default:              thresh = uart_rx_pkg::fill_t'(14);
    endcase
  end

  assign trigger_o = (count_q >= thresh);

  // --------------------
  // Pointers, fill count, overrun
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      overrun_o <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps with the depth
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;         // Both or neither
      endcase
      overrun_o <= push_i & ~do_push;        // Character dropped, store untouched
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= char_i;
    end
  end

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   oversample_tick_i,
  input  logic                   rxd_i,
  input  uart_rx_pkg::line_cfg_t cfg_i,
  input  logic                   pop_i,
  output uart_rx_pkg::rx_char_t  char_o,
  output logic                   not_empty_o,
  output logic                   trigger_o,
  output logic                   overrun_o
);

  uart_rx_pkg::sample_t  sample;      // Sampler to FSM
  logic                  hunt;        // FSM waiting for a start bit
  logic                  char_valid;
  uart_rx_pkg::rx_char_t frame_char;

  // --------------------
  // Input sampler
  uart_rx_sampler i_sampler (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .oversample_tick_i (oversample_tick_i),
    .rxd_i             (rxd_i),
    .hunt_i            (hunt),
    .sample_o          (sample)
  );

  // Frame FSM
  uart_rx_frame i_frame (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .sample_i     (sample),
    .cfg_i        (cfg_i),
    .hunt_o       (hunt),
    .char_valid_o (char_valid),
    .char_o       (frame_char)
  );

  // Receive FIFO, only the threshold comes from the line settings
  uart_rx_fifo i_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (char_valid),
    .char_i       (frame_char),
    .pop_i        (pop_i),
    .trig_level_i (cfg_i.trig_level),
    .char_o       (char_o),
    .not_empty_o  (not_empty_o),
    .trigger_o    (trigger_o),
    .overrun_o    (overrun_o)
  );

endmodule

// File: verification/uart_rx_tb.sv
`timescale 1ns/10ps

module uart_rx_tb;

  logic                   clk;
  logic                   rst_n;
  logic                   tick = 1'b0;       // Oversample strobe
  logic                   rxd;
  logic                   pop = 1'b0;
  uart_rx_pkg::line_cfg_t cfg;
  uart_rx_pkg::rx_char_t  rx_char;
  logic                   not_empty;
  logic                   trigger;
  logic                   overrun;

  uart_rx_pkg::rx_char_t  exp_q[$];          // Characters still to come out
  uart_rx_pkg::rx_char_t  exp_head;
  string                  test_name;
  logic                   popping;           // Compare process may pop
  int                     stored;            // Own count of FIFO entries
  int                     overrun_cnt = 0;
  int                     cycles = 0;

  uart_rx dut (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .oversample_tick_i (tick),
    .rxd_i             (rxd),
    .cfg_i             (cfg),
    .pop_i             (pop),
    .char_o            (rx_char),
    .not_empty_o       (not_empty),
    .trigger_o         (trigger),
    .overrun_o         (overrun)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  // Tick on every second clock so a bit lasts 32 clocks
  always @(posedge clk) begin
    #1;
    tick = ~tick;
  end

  // --------------------
  // Reference model
  function automatic int data_bits(uart_rx_pkg::line_cfg_t c);
    return 5 + int'(c.word_len);
  endfunction

  function automatic logic [7:0] mask_data(logic [7:0] d, uart_rx_pkg::line_cfg_t c);
    return d & (8'hFF >> (8 - data_bits(c)));
  endfunction

  // Bit a correct transmitter puts on the line
  function automatic logic parity_bit(logic [7:0] d, uart_rx_pkg::line_cfg_t c);
    case (c.parity)
      uart_rx_pkg::PARITY_ODD:  return ~(^d);
      uart_rx_pkg::PARITY_EVEN: return ^d;
      uart_rx_pkg::PARITY_ONE:  return 1'b1;
      default:                  return 1'b0;
    endcase
  endfunction

  function automatic uart_rx_pkg::rx_char_t expected_char(logic [7:0] d,
      uart_rx_pkg::line_cfg_t c, logic bad_par, logic zero_stop);
    uart_rx_pkg::rx_char_t r;
    logic [7:0]            m;
    logic                  p;
    m = mask_data(d, c);
    p = parity_bit(m, c) ^ bad_par;  // Received parity bit
    r.data        = m;
    r.framing_err = zero_stop;
    r.parity_err  = c.parity_en && bad_par;  // Only an inverted bit breaks the mode's rule
    r.brk = zero_stop && (m == '0) && !(c.parity_en && p);  // Whole frame low
    return r;
  endfunction

  function automatic int trig_threshold(uart_rx_pkg::trig_level_e l);
    case (l)
      uart_rx_pkg::TRIG_1: return 1;
      uart_rx_pkg::TRIG_4: return 4;
      uart_rx_pkg::TRIG_8: return 8;
      default:             return 14;
    endcase
  endfunction

  // --------------------
  // Serial driver
  task automatic wait_ticks(int n);
    repeat (n) begin
      @(posedge clk);
      while (!tick) @(posedge clk);
    end
    #1;                                      // Drive point after the edge
  endtask

  task automatic send_bit(logic b);
    rxd = b;
    wait_ticks(16);
  endtask

  task automatic send_frame(logic [7:0] d, logic bad_par, logic zero_stop, logic glitch);
    logic [7:0] m;
    m = mask_data(d, cfg);
    send_bit(1'b0);                          // Start
    for (int i = 0; i < data_bits(cfg); i++) begin
      if (glitch && i == 3) begin
        // Single low tick inside a high bit hits the first filter sample
        rxd = 1'b1;
        wait_ticks(5);
        rxd = 1'b0;
        wait_ticks(1);
        rxd = 1'b1;
        wait_ticks(10);
      end else begin
        send_bit(m[i]);                      // LSB first
      end
    end
    if (cfg.parity_en) send_bit(parity_bit(m, cfg) ^ bad_par);
    send_bit(~zero_stop);
    rxd = 1'b1;
  endtask

  task automatic send_char(logic [7:0] d, logic bad_par, logic zero_stop);
    exp_q.push_back(expected_char(d, cfg, bad_par, zero_stop));
    send_frame(d, bad_par, zero_stop, 1'b0);
  endtask

  // Low stop bit doubles as a start bit and the idle line then reads as all ones
  task automatic recover_after_low_stop();
    exp_q.push_back(expected_char(8'hFF, cfg,
                                  ~parity_bit(mask_data(8'hFF, cfg), cfg), 1'b0));
    wait_ticks(16 * (data_bits(cfg) + 3));
  endtask

  task automatic drain();
    popping = 1'b1;
    while (exp_q.size() != 0) @(posedge clk);
    wait_ticks(2);
  endtask

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_trigger();
    logic want;
    want = (stored >= trig_threshold(cfg.trig_level));
    assert (trigger === want) else begin
      $display("[FAIL] %s: expected trigger %0b, actual %0b with %0d stored",
               test_name, want, trigger, stored);
      abort_run();
    end
  endtask

  // --------------------
  // Compare process popping the head whenever one is waiting
  always @(posedge clk) begin
    #1;
    pop = 1'b0;
    if (popping && not_empty) begin
      assert (exp_q.size() != 0) else begin
        $display("%s: the FIFO delivered a character that was never sent", test_name);
        abort_run();
      end
      exp_head = exp_q.pop_front();
      assert (rx_char === exp_head) else begin
        $display("[FAIL] %s: expected %h, actual %h", test_name, exp_head, rx_char);
        abort_run();
      end
      pop = 1'b1;
    end
  end

  always @(posedge clk) begin
    #1;
    if (overrun) overrun_cnt++;              // One count per pulse
  end

  // About 870 bits at 32 clocks each plus margin
  always @(posedge clk) begin
    cycles++;
    if (cycles > 40000) begin
      $display("Timeout: the run went past 40000 clock cycles");
      abort_run();
    end
  end

  // --------------------
  // Test sequence
  initial begin
    logic [7:0] d;
    void'($urandom(32));
    rst_n = 1'b0;
    rxd   = 1'b1;                            // Idle line
    popping = 1'b1;
    test_name = "reset";
    cfg.word_len   = uart_rx_pkg::WORD_LEN_8;
    cfg.parity_en  = 1'b0;
    cfg.parity     = uart_rx_pkg::PARITY_EVEN;
    cfg.trig_level = uart_rx_pkg::TRIG_1;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    wait_ticks(4);

    test_name = "basic";
    for (int i = 0; i < 20; i++) begin
      d = 8'($urandom);
      if (i == 7) begin
        d[3] = 1'b1;                         // Glitch needs a high bit
        exp_q.push_back(expected_char(d, cfg, 1'b0, 1'b0));
        send_frame(d, 1'b0, 1'b0, 1'b1);
      end else begin
        send_char(d, 1'b0, 1'b0);
      end
    end
    drain();

    test_name = "word_length";
    for (int w = 0; w < 3; w++) begin
      cfg.word_len = uart_rx_pkg::word_len_e'(w);
      send_char(8'hFF, 1'b0, 1'b0);          // Upper bits must come back zero
      send_char(8'($urandom), 1'b0, 1'b0);
    end
    drain();

    test_name = "parity";
    cfg.word_len  = uart_rx_pkg::WORD_LEN_8;
    cfg.parity_en = 1'b1;
    for (int p = 0; p < 4; p++) begin
      cfg.parity = uart_rx_pkg::parity_e'(p);
      d = 8'($urandom);
      send_char(d, 1'b0, 1'b0);
      send_char(d, 1'b1, 1'b0);              // Inverted parity bit
    end
    drain();

    test_name = "stop_break";
    cfg.parity_en = 1'b0;
    send_char(8'h5A, 1'b0, 1'b1);            // Framing error only
    recover_after_low_stop();
    send_char(8'h00, 1'b0, 1'b1);            // Break
    recover_after_low_stop();
    send_char(8'hC3, 1'b0, 1'b0);
    drain();

    test_name = "trigger";
    for (int t = 0; t < 4; t++) begin
      cfg.trig_level = uart_rx_pkg::trig_level_e'(t);
      popping = 1'b0;
      stored  = 0;
      check_trigger();
      repeat (trig_threshold(cfg.trig_level) + 1) begin
        send_char(8'($urandom), 1'b0, 1'b0);
        stored++;
        check_trigger();
      end
      drain();
    end

    test_name = "overrun";
    assert (overrun_cnt == 0) else begin
      $display("Overrun was reported before the FIFO was ever full");
      abort_run();
    end
    popping = 1'b0;
    for (int i = 0; i < 16; i++) send_char(8'($urandom), 1'b0, 1'b0);
    send_frame(8'($urandom), 1'b0, 1'b0, 1'b0);  // Meets a full FIFO
    assert (overrun_cnt == 1) else begin
      $display("[FAIL] %s: expected 1 pulse, actual %0d", test_name, overrun_cnt);
      abort_run();
    end
    drain();

    $display("Test passed");
    $finish;
  end

endmodule

// File: src.f
rtl/uart_rx_pkg.sv
rtl/uart_rx_sampler.sv
rtl/uart_rx_frame.sv
rtl/uart_rx_fifo.sv
rtl/uart_rx.sv
verification/uart_rx_tb.sv

// File: Makefile
# Verilator build and run of the UART receiver testbench

SIM := obj_dir/Vuart_rx_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): src.f $(wildcard rtl/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module uart_rx_tb -Mdir obj_dir -f src.f

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "Test passed" sim.log || \
	  (echo "Simulation did not pass, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
